// ==== verilog/raycast_settings.svh ====
`ifndef RAYCAST_SETTINGS_SVH
`define RAYCAST_SETTINGS_SVH

// screen
`define RC_SCREEN_HEIGHT 240  // pixels, numerator of the line height division

// tile map, stored row by row (x + N*y)
`define RC_MAP_N      24      // tiles per side
`define RC_MAP_ADDR_W 10      // covers 24*24 = 576 cells

// column index and fixed-point words
`define RC_COL_W  9           // 320 columns
`define RC_FIX_W  16          // 8.8 unsigned
`define RC_FRAC_W 8           // fraction bits of an 8.8 word

// upper bound on cells visited by one ray
// a bordered 24x24 map is crossed in well under this
`define RC_MAX_STEPS 64

`endif

// ==== verilog/raycast_pkg.sv ====
`include "raycast_settings.svh"

package raycast_pkg;

  // one ray to march, set up upstream
  // all distances and directions are unsigned 8.8
  typedef struct packed {
    logic [`RC_COL_W-1:0] column;     // screen column this ray belongs to
    logic                 step_x;     // 1 steps +1, 0 steps -1
    logic                 step_y;
    logic [`RC_FIX_W-1:0] ray_dir_x;  // magnitude only, sign is in step_x
    logic [`RC_FIX_W-1:0] ray_dir_y;
    logic [`RC_FIX_W-1:0] delta_x;    // ray length between two x sides
    logic [`RC_FIX_W-1:0] delta_y;
    logic [`RC_FIX_W-1:0] pos_x;      // player position
    logic [`RC_FIX_W-1:0] pos_y;
    logic [`RC_FIX_W-1:0] side_x;     // ray length to the first x side
    logic [`RC_FIX_W-1:0] side_y;
  } ray_job_t;

  // one finished column
  typedef struct packed {
    logic [`RC_COL_W-1:0] column;
    logic [7:0]           line_height;  // pixels, capped at 255
    logic                 y_side;       // 0 means an x side was hit
    logic [3:0]           tile;         // wall type from the map
    logic [7:0]           wall_x;       // hit position along the wall, fraction only
    logic [`RC_FIX_W-1:0] perp_dist;    // 8.8
  } ray_hit_t;

  // map read request
  typedef struct packed {
    logic [`RC_MAP_ADDR_W-1:0] addr;  // x + 24*y
  } map_rd_t;

endpackage

// ==== verilog/fixed_divider.sv ====
`timescale 1ns/1ns
`include "raycast_settings.svh"

module fixed_divider #(
  parameter int WIDTH = 16
) (
  input  logic             pixel_clk_in,
  input  logic             rst_in,
  input  logic             start,     // operands are sampled with this pulse
  input  logic [WIDTH-1:0] dividend,  // unsigned fixed point
  input  logic [WIDTH-1:0] divisor,
  output logic [WIDTH-1:0] quotient,  // same format, kept until the next start
  output logic             done,      // one cycle
  output logic             busy
);

  localparam int FB    = `RC_FRAC_W;
  localparam int CNT_W = $clog2(WIDTH + 1);

  logic [WIDTH-1:0] rem;    // partial remainder
  logic [WIDTH-1:0] num;    // numerator bits not yet shifted in
  logic [WIDTH-1:0] den;
  logic [CNT_W-1:0] cnt;    // quotient bits left
  logic             sat;    // quotient will not fit in WIDTH bits
  logic [WIDTH:0]   trial;
  logic [WIDTH:0]   diff;
  logic             q_bit;

  assign trial = {rem, num[WIDTH-1]};
  assign diff  = trial - {1'b0, den};
  assign q_bit = ~diff[WIDTH];  // no borrow, divisor fits

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt  <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= CNT_W'(WIDTH);
      end else if (busy) begin
        cnt <= cnt - 1'b1;
        if (cnt == CNT_W'(1)) begin  // last bit lands this cycle
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // numerator is dividend << FB; its top FB bits give zero quotient bits
  // unless the result overflows, so they go straight into the remainder
  always_ff @(posedge pixel_clk_in) begin
    if (start) begin
      rem <= dividend >> (WIDTH - FB);
      num <= dividend << FB;
      den <= divisor;
      sat <= (dividend >> (WIDTH - FB)) >= divisor;  // also true for divisor 0
    end else if (busy) begin
      rem      <= q_bit ? diff[WIDTH-1:0] : trial[WIDTH-1:0];
      num      <= num << 1;
      quotient <= (cnt == CNT_W'(1) && sat) ? '1 : {quotient[WIDTH-2:0], q_bit};
    end
  end

endmodule

// ==== verilog/map_rom.sv ====
`timescale 1ns/1ns
`include "raycast_settings.svh"

module map_rom (
  input  logic                 pixel_clk_in,
  input  logic                 rst_in,
  input  raycast_pkg::map_rd_t rd,
  input  logic                 req,
  output logic                 ack,
  output logic [3:0]           tile
);

  // one nibble per cell, row major
  logic [3:0] tiles [`RC_MAP_N * `RC_MAP_N];

  initial begin
    $readmemh("map.hex", tiles);
  end

  // ack trails req by one cycle on both edges
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      ack <= 1'b0;
    end else begin
      ack <= req;
    end
  end

  // capture once per request, stays put while ack is high
  always_ff @(posedge pixel_clk_in) begin
    if (req && !ack) begin
      tile <= tiles[rd.addr];
    end
  end

endmodule

// ==== verilog/map_arbiter.sv ====
`timescale 1ns/1ns

module map_arbiter (
  input  logic                 pixel_clk_in,
  input  logic                 rst_in,
  input  raycast_pkg::map_rd_t rd [2],   // per walker
  input  logic [1:0]           req,
  output logic [1:0]           ack,
  output logic [3:0]           tile,
  output raycast_pkg::map_rd_t rom_rd,
  output logic                 rom_req,
  input  logic                 rom_ack,
  input  logic [3:0]           rom_tile
);

  logic locked;  // a transaction is in flight
  logic owner;   // walker holding the grant, also the last one served
  logic pick;

  // on a tie the walker not served last time wins
  assign pick = (req == 2'b11) ? ~owner : req[1];

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      locked <= 1'b0;
      owner  <= 1'b1;  // walker 0 wins the first tie
    end else if (!locked) begin
      if (|req) begin
        locked <= 1'b1;
        owner  <= pick;
      end
    end else if (!req[owner] && !rom_ack) begin
      locked <= 1'b0;  // all four phases done
    end
  end

  // rom side follows the owner only
  assign rom_req = locked & req[owner];
  assign rom_rd  = rd[owner];

  // ack routed back to the owner, tile is shared
  assign ack[0] = locked & ~owner & rom_ack;
  assign ack[1] = locked & owner & rom_ack;
  assign tile   = rom_tile;

  // rom acknowledge only ever answers a walker that holds the grant
  a_ack_in_grant: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    rom_ack |-> locked);

endmodule

// ==== verilog/dda_walker.sv ====
`timescale 1ns/1ns
`include "raycast_settings.svh"

module dda_walker (
  input  logic                  pixel_clk_in,
  input  logic                  rst_in,
  input  raycast_pkg::ray_job_t job,
  input  logic                  start,     // one cycle, job valid
  output logic                  idle,
  output raycast_pkg::ray_hit_t hit,
  output logic                  done,      // result waiting to be taken
  input  logic                  taken,
  output raycast_pkg::map_rd_t  map_rd,
  output logic                  map_req,
  input  logic                  map_ack,
  input  logic [3:0]            map_tile
);

  typedef enum logic [2:0] {
    S_IDLE, S_STEP, S_ACK, S_REL, S_DIV, S_WAIT, S_DONE
  } state_t;

  state_t                             state;
  raycast_pkg::ray_job_t              ray;     // job being marched
  logic [7:0]                         cell_x;  // current map cell
  logic [7:0]                         cell_y;
  logic [`RC_FIX_W-1:0]               side_x;
  logic [`RC_FIX_W-1:0]               side_y;
  logic                               y_side;  // axis of the last step
  logic [3:0]                         tile_q;
  logic [`RC_FIX_W-1:0]               perp_q;
  logic [2*`RC_FIX_W-1:0]             prod_q;  // perp * other ray dir, 16.16
  logic [$clog2(`RC_MAX_STEPS+1)-1:0] steps;

  logic                 go_x;
  logic [7:0]           nx;
  logic [7:0]           ny;
  logic [`RC_FIX_W-1:0] perp_c;
  logic [`RC_FIX_W-1:0] oth_dir;
  logic [7:0]           oth_frac;
  logic [7:0]           oth_ofs;
  logic                 oth_step;
  logic                 div_start;
  logic                 div_done;
  logic                 div_busy;
  logic [`RC_FIX_W-1:0] quotient;

  assign go_x = side_x < side_y;  // ties go to y
  assign nx   = go_x ? (ray.step_x ? cell_x + 8'd1 : cell_x - 8'd1) : cell_x;
  assign ny   = go_x ? cell_y : (ray.step_y ? cell_y + 8'd1 : cell_y - 8'd1);

  // side distance has already moved one delta past the wall
  assign perp_c = y_side ? side_y - ray.delta_y : side_x - ray.delta_x;

  // wall_x runs along the axis that was not crossed
  assign oth_dir  = y_side ? ray.ray_dir_x : ray.ray_dir_y;
  assign oth_frac = y_side ? ray.pos_x[7:0] : ray.pos_y[7:0];
  assign oth_step = y_side ? ray.step_x : ray.step_y;
  assign oth_ofs  = prod_q[15:8];  // fraction of (perp*dir) >> 8

  assign idle      = (state == S_IDLE) && !div_busy;
  assign done      = state == S_DONE;
  assign div_start = state == S_DIV;

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      state   <= S_IDLE;
      map_req <= 1'b0;
    end else begin
      case (state)
        S_IDLE: if (start) state <= S_STEP;
        S_STEP: begin
          map_req <= 1'b1;  // address is registered on the same edge
          state   <= S_ACK;
        end
        S_ACK: if (map_ack) begin
          map_req <= 1'b0;
          state   <= S_REL;
        end
        S_REL: if (!map_ack) state <= (tile_q != 4'd0) ? S_DIV : S_STEP;
        S_DIV:  state <= S_WAIT;  // divider start pulse
        S_WAIT: if (div_done) state <= S_DONE;
        S_DONE: if (taken) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    case (state)
      S_IDLE: if (start) begin
        ray    <= job;
        side_x <= job.side_x;
        side_y <= job.side_y;
        cell_x <= job.pos_x[15:8];  // integer part is the start cell
        cell_y <= job.pos_y[15:8];
        steps  <= '0;
      end
      S_STEP: begin
        if (go_x) side_x <= side_x + ray.delta_x;
        else      side_y <= side_y + ray.delta_y;
        cell_x      <= nx;
        cell_y      <= ny;
        y_side      <= !go_x;
        map_rd.addr <= `RC_MAP_ADDR_W'(int'(nx) + int'(ny) * `RC_MAP_N);
        steps       <= steps + 1'b1;
      end
      S_ACK: if (map_ack) tile_q <= map_tile;
      S_REL: if (!map_ack && tile_q != 4'd0) begin
        perp_q <= perp_c;
        prod_q <= perp_c * oth_dir;
      end
      S_WAIT: if (div_done) begin
        hit.column      <= ray.column;
        hit.line_height <= quotient[15:8];  // divider already caps at 0xFFFF
        hit.y_side      <= y_side;
        hit.tile        <= tile_q;
        hit.wall_x      <= oth_step ? oth_frac + oth_ofs : oth_frac - oth_ofs;
        hit.perp_dist   <= perp_q;
      end
      default: ;
    endcase
  end

  // line height = 240.0 / perp
  fixed_divider #(.WIDTH(`RC_FIX_W)) divider (
    .pixel_clk_in(pixel_clk_in),
    .rst_in      (rst_in),
    .start       (div_start),
    .dividend    (`RC_FIX_W'(`RC_SCREEN_HEIGHT << `RC_FRAC_W)),
    .divisor     (perp_q),
    .quotient    (quotient),
    .done        (div_done),
    .busy        (div_busy)
  );

  // walker must never look outside the map
  a_addr_in_map: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    map_req |-> map_rd.addr < `RC_MAP_N * `RC_MAP_N);

  a_step_limit: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    state != S_IDLE |-> steps <= `RC_MAX_STEPS);

endmodule

// ==== verilog/column_scheduler.sv ====
`timescale 1ns/1ns

module column_scheduler (
  input  logic                  pixel_clk_in,
  input  logic                  rst_in,
  input  raycast_pkg::ray_job_t job,
  input  logic                  job_req,
  output logic                  job_ack,
  output raycast_pkg::ray_hit_t hit,
  output logic                  hit_req,
  input  logic                  hit_ack,
  output raycast_pkg::ray_job_t walk_job,    // shared by both walkers
  output logic [1:0]            walk_start,
  input  logic [1:0]            walk_idle,
  input  raycast_pkg::ray_hit_t walk_hit [2],
  input  logic [1:0]            walk_done,
  output logic [1:0]            walk_taken
);

  typedef enum logic [1:0] {O_IDLE, O_REQ, O_REL} out_state_t;

  out_state_t out_state;
  logic       out_sel;  // walker whose result is on hit
  logic       accept;
  logic       pick;

  // new job with a free walker, ack not yet given
  assign accept = job_req && !job_ack && |walk_idle;

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      job_ack    <= 1'b0;
      walk_start <= 2'b00;
    end else begin
      walk_start <= 2'b00;
      if (accept) begin
        job_ack    <= 1'b1;
        walk_start <= walk_idle[0] ? 2'b01 : 2'b10;  // lowest idle first
      end else if (job_ack && !job_req) begin
        job_ack <= 1'b0;
      end
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (accept) walk_job <= job;
  end

  // both done: alternate, else whoever is done
  assign pick = (walk_done == 2'b11) ? ~out_sel : walk_done[1];

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      out_state <= O_IDLE;
      out_sel   <= 1'b1;
    end else begin
      case (out_state)
        O_IDLE: if (|walk_done) begin
          out_sel   <= pick;
          out_state <= O_REQ;
        end
        O_REQ: if (hit_ack) out_state <= O_REL;
        O_REL: if (!hit_ack) out_state <= O_IDLE;  // walker freed on this edge
        default: out_state <= O_IDLE;
      endcase
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (out_state == O_IDLE && |walk_done) hit <= walk_hit[pick];
  end

  assign hit_req    = out_state == O_REQ;
  assign walk_taken = (out_state == O_REL && !hit_ack) ? (out_sel ? 2'b10 : 2'b01) : 2'b00;

  a_start_idle: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    (walk_start & ~walk_idle) == 2'b00);

endmodule

// ==== verilog/raycast_core.sv ====
`timescale 1ns/1ns

module raycast_core (
  input  logic                  pixel_clk_in,
  input  logic                  rst_in,
  input  raycast_pkg::ray_job_t job,
  input  logic                  job_req,
  output logic                  job_ack,
  output raycast_pkg::ray_hit_t hit,
  output logic                  hit_req,
  input  logic                  hit_ack
);

  raycast_pkg::ray_job_t walk_job;
  raycast_pkg::ray_hit_t walk_hit [2];
  raycast_pkg::map_rd_t  walk_rd [2];  // per-walker map address
  logic [1:0]            walk_start;
  logic [1:0]            walk_idle;
  logic [1:0]            walk_done;
  logic [1:0]            walk_taken;
  logic [1:0]            walk_map_req;
  logic [1:0]            walk_map_ack;
  logic [3:0]            walk_tile;    // shared, qualified by ack
  raycast_pkg::map_rd_t  rom_rd;
  logic                  rom_req;
  logic                  rom_ack;
  logic [3:0]            rom_tile;

  column_scheduler scheduler (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in),
    .job(job), .job_req(job_req), .job_ack(job_ack),
    .hit(hit), .hit_req(hit_req), .hit_ack(hit_ack),
    .walk_job(walk_job), .walk_start(walk_start), .walk_idle(walk_idle),
    .walk_hit(walk_hit), .walk_done(walk_done), .walk_taken(walk_taken)
  );

  dda_walker walker_0 (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in),
    .job(walk_job), .start(walk_start[0]), .idle(walk_idle[0]),
    .hit(walk_hit[0]), .done(walk_done[0]), .taken(walk_taken[0]),
    .map_rd(walk_rd[0]), .map_req(walk_map_req[0]), .map_ack(walk_map_ack[0]),
    .map_tile(walk_tile)
  );

  dda_walker walker_1 (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in),
    .job(walk_job), .start(walk_start[1]), .idle(walk_idle[1]),
    .hit(walk_hit[1]), .done(walk_done[1]), .taken(walk_taken[1]),
    .map_rd(walk_rd[1]), .map_req(walk_map_req[1]), .map_ack(walk_map_ack[1]),
    .map_tile(walk_tile)
  );

  map_arbiter arbiter (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in),
    .rd(walk_rd), .req(walk_map_req), .ack(walk_map_ack), .tile(walk_tile),
    .rom_rd(rom_rd), .rom_req(rom_req), .rom_ack(rom_ack), .rom_tile(rom_tile)
  );

  map_rom rom (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in),
    .rd(rom_rd), .req(rom_req), .ack(rom_ack), .tile(rom_tile)
  );

endmodule

// ==== bench/raycast_tb.sv ====
`timescale 1ns/1ns
`include "raycast_settings.svh"

module raycast_tb;

  localparam int WAIT_LIMIT = 5000;  // cycles allowed for any single wait

  logic                  pixel_clk_in;
  logic                  rst_in;
  raycast_pkg::ray_job_t job;
  logic                  job_req;
  logic                  job_ack;
  raycast_pkg::ray_hit_t hit;
  logic                  hit_req;
  logic                  hit_ack;

  logic [3:0]            map_tiles [`RC_MAP_N * `RC_MAP_N];  // own copy of the map
  raycast_pkg::ray_hit_t expect_tab [1 << `RC_COL_W];        // expected result per column
  bit                    pending [1 << `RC_COL_W];           // column sent, not yet returned
  int                    seed = 55;
  int                    sent = 0;
  int                    received = 0;
  int                    ack_delay_max = 0;  // 0 acks a result right away
  int                    stall_cycles = 0;   // job waiting while both walkers hold results
  string                 test_name = "reset";

  raycast_core dut (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in),
    .job(job), .job_req(job_req), .job_ack(job_ack),
    .hit(hit), .hit_req(hit_req), .hit_ack(hit_ack)
  );

  initial begin
    pixel_clk_in = 1'b0;
    forever #5 pixel_clk_in = ~pixel_clk_in;
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      stop_with_failure($sformatf("[FAIL] %s %s: expected %0h actual %0h",
                                  test_name, what, expected, actual));
    end
  endtask

  // job from a cell, a fraction inside it, step signs and |ray dir|, all 8.8
  function automatic raycast_pkg::ray_job_t make_job(input int col, input int cx, input int cy,
      input int fx, input int fy, input bit sx, input bit sy, input int dir_x, input int dir_y);
    raycast_pkg::ray_job_t j;
    int dlx;
    int dly;
    int six;
    int siy;
    dlx = 65536 / dir_x;  // 1.0 / dir in 8.8
    dly = 65536 / dir_y;
    if (dlx > 'hFFFF) dlx = 'hFFFF;
    if (dly > 'hFFFF) dly = 'hFFFF;
    six = sx ? ((256 - fx) * dlx) >> 8 : (fx * dlx) >> 8;  // distance to the first x side
    siy = sy ? ((256 - fy) * dly) >> 8 : (fy * dly) >> 8;
    if (six > 'hFFFF) six = 'hFFFF;
    if (siy > 'hFFFF) siy = 'hFFFF;
    j.column    = `RC_COL_W'(col);
    j.step_x    = sx;
    j.step_y    = sy;
    j.ray_dir_x = 16'(dir_x);
    j.ray_dir_y = 16'(dir_y);
    j.delta_x   = 16'(dlx);
    j.delta_y   = 16'(dly);
    j.pos_x     = 16'(cx * 256 + fx);
    j.pos_y     = 16'(cy * 256 + fy);
    j.side_x    = 16'(six);
    j.side_y    = 16'(siy);
    return j;
  endfunction

  // marches the ray on the tb map copy and builds the expected column result
  function automatic raycast_pkg::ray_hit_t reference_hit(input raycast_pkg::ray_job_t j);
    raycast_pkg::ray_hit_t r;
    int     cx;
    int     cy;
    int     side_x;
    int     side_y;
    int     tile;
    int     steps;
    int     perp;
    int     frac;
    bit     ys;
    bit     up;
    longint q;
    longint ofs;
    cx     = int'(j.pos_x[15:8]);
    cy     = int'(j.pos_y[15:8]);
    side_x = int'(j.side_x);
    side_y = int'(j.side_y);
    tile   = 0;
    steps  = 0;
    ys     = 1'b0;
    while (tile == 0 && steps < `RC_MAX_STEPS) begin
      if (side_x < side_y) begin  // equal sides step along y
        side_x = (side_x + int'(j.delta_x)) & 'hFFFF;
        cx     = j.step_x ? cx + 1 : cx - 1;
        ys     = 1'b0;
      end else begin
        side_y = (side_y + int'(j.delta_y)) & 'hFFFF;
        cy     = j.step_y ? cy + 1 : cy - 1;
        ys     = 1'b1;
      end
      tile = int'(map_tiles[cx + `RC_MAP_N * cy]);
      steps++;
    end
    perp = (ys ? side_y - int'(j.delta_y) : side_x - int'(j.delta_x)) & 'hFFFF;
    q    = (perp == 0) ? 'hFFFF : (longint'(`RC_SCREEN_HEIGHT) << 16) / perp;  // 240.0 / perp
    if (q > 'hFFFF) q = 'hFFFF;
    ofs  = ((longint'(perp) * (ys ? j.ray_dir_x : j.ray_dir_y)) >> 8) & 'hFF;
    frac = ys ? int'(j.pos_x[7:0]) : int'(j.pos_y[7:0]);
    up   = ys ? j.step_x : j.step_y;
    r.column      = j.column;
    r.line_height = q[15:8];
    r.y_side      = ys;
    r.tile        = tile[3:0];
    r.wall_x      = up ? 8'(frac + ofs) : 8'(frac - ofs);
    r.perp_dist   = perp[15:0];
    return r;
  endfunction

  task automatic build_random_job(input int col, output raycast_pkg::ray_job_t j);
    int cx;
    int cy;
    do begin
      cx = 1 + ({$random(seed)} % 22);
      cy = 1 + ({$random(seed)} % 22);
    end while (map_tiles[cx + `RC_MAP_N * cy] != 4'd0);  // start in an open cell
    j = make_job(col, cx, cy, {$random(seed)} % 256, {$random(seed)} % 256,
                 $random(seed), $random(seed),
                 'h20 + ({$random(seed)} % 'h100), 'h20 + ({$random(seed)} % 'h100));
  endtask

  // four-phase job handshake, called and left on a falling edge
  task automatic send_job(input raycast_pkg::ray_job_t j);
    int t;
    bit full;
    expect_tab[j.column] = reference_hit(j);
    pending[j.column]    = 1'b1;
    sent++;
    job     = j;
    job_req = 1'b1;
    t = 0;
    while (!job_ack) begin
      full = dut.walk_done == 2'b11;  // both walkers hold results, no room for this job
      if (full) stall_cycles++;
      @(negedge pixel_clk_in);
      t++;
      if (full) check_value("job_ack while both walkers held results", 1'b0, job_ack);
      if (t > WAIT_LIMIT) stop_with_failure("timeout: job_ack never rose for a job");
    end
    job_req = 1'b0;
    t = 0;
    while (job_ack) begin
      @(negedge pixel_clk_in);
      t++;
      if (t > WAIT_LIMIT) stop_with_failure("timeout: job_ack stayed high after job_req fell");
    end
  endtask

  task automatic wait_for_results();
    int t;
    t = 0;
    while (received != sent) begin
      @(negedge pixel_clk_in);
      t++;
      if (t > WAIT_LIMIT) stop_with_failure("timeout: not every sent column came back");
    end
  endtask

  task automatic send_and_wait(input raycast_pkg::ray_job_t j);
    send_job(j);
    wait_for_results();
  endtask

  // output side: runs the result handshake and compares against the table
  initial begin : collect_results
    raycast_pkg::ray_hit_t got;
    raycast_pkg::ray_hit_t exp;
    int t;
    int d;
    forever begin
      t = 0;
      @(negedge pixel_clk_in);
      while (!hit_req) begin
        t++;
        if (t > WAIT_LIMIT) stop_with_failure("timeout: no result came out of the core");
        @(negedge pixel_clk_in);
      end
      got = hit;
      if (!pending[got.column]) begin
        stop_with_failure($sformatf("column %0d came back without a pending job", got.column));
      end
      exp = expect_tab[got.column];
      check_value($sformatf("col %0d tile", got.column), exp.tile, got.tile);
      check_value($sformatf("col %0d y_side", got.column), exp.y_side, got.y_side);
      check_value($sformatf("col %0d perp_dist", got.column), exp.perp_dist, got.perp_dist);
      check_value($sformatf("col %0d line_height", got.column), exp.line_height,
                  got.line_height);
      check_value($sformatf("col %0d wall_x", got.column), exp.wall_x, got.wall_x);
      pending[got.column] = 1'b0;  // a second copy of this column now fails
      received++;
      d = (ack_delay_max == 0) ? 0 : {$random(seed)} % (ack_delay_max + 1);
      repeat (d) @(negedge pixel_clk_in);
      hit_ack = 1'b1;
      t = 0;
      while (hit_req) begin
        @(negedge pixel_clk_in);
        t++;
        if (t > WAIT_LIMIT) stop_with_failure("timeout: hit_req stayed high after hit_ack");
      end
      hit_ack = 1'b0;
    end
  end

  initial begin : run_tests
    raycast_pkg::ray_job_t j;
    int col;
    int stalls_before;
    rst_in  = 1'b1;
    job     = '0;
    job_req = 1'b0;
    hit_ack = 1'b0;
    $readmemh("map.hex", map_tiles);
    repeat (4) @(negedge pixel_clk_in);  // 4 rising edges in reset
    rst_in = 1'b0;

    test_name = "axis_rays";  // one step to the east wall, then long runs on each axis
    send_and_wait(make_job(0, 22, 12, 'h40, 'h80, 1'b1, 1'b1, 'h80, 'h01));
    send_and_wait(make_job(1, 12, 12, 'h30, 'h80, 1'b0, 1'b1, 'h100, 'h01));
    send_and_wait(make_job(2, 12, 12, 'h80, 'h30, 1'b1, 1'b1, 'h01, 'h100));
    send_and_wait(make_job(3, 12, 12, 'h80, 'h30, 1'b1, 1'b0, 'h01, 'h100));

    test_name = "close_walls";  // under 240/255 from the wall
    send_and_wait(make_job(4, 1, 12, 'h20, 'h80, 1'b0, 1'b1, 'h100, 'h01));
    send_and_wait(make_job(5, 6, 8, 'h80, 'h10, 1'b1, 1'b0, 'h01, 'h100));

    test_name = "wall_x";  // every combination of step signs
    send_and_wait(make_job(6, 12, 12, 'h5A, 'hC3, 1'b1, 1'b1, 'hB5, 'h6A));
    send_and_wait(make_job(7, 12, 12, 'h5A, 'hC3, 1'b0, 1'b1, 'h6A, 'hB5));
    send_and_wait(make_job(8, 12, 12, 'h5A, 'hC3, 1'b1, 1'b0, 'h6A, 'hB5));
    send_and_wait(make_job(9, 12, 12, 'h5A, 'hC3, 1'b0, 1'b0, 'hB5, 'h6A));

    test_name = "back_to_back";
    for (col = 10; col < 50; col++) begin
      build_random_job(col, j);
      send_job(j);
    end
    wait_for_results();

    test_name     = "output_backpressure";  // slow consumer, results pile up in the walkers
    ack_delay_max = 63;
    stalls_before = stall_cycles;
    for (col = 50; col < 74; col++) begin
      build_random_job(col, j);
      send_job(j);
    end
    wait_for_results();

    if (stall_cycles > stalls_before) begin
      $display("TEST OK");
      $finish;
    end else begin
      stop_with_failure("job_ack never stalled while both walkers held results");
    end
  end

endmodule

// ==== raycast.f ====
+incdir+verilog
verilog/raycast_pkg.sv
verilog/fixed_divider.sv
verilog/map_rom.sv
verilog/map_arbiter.sv
verilog/dda_walker.sv
verilog/column_scheduler.sv
verilog/raycast_core.sv
bench/raycast_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the raycast testbench with Verilator, run it, decide on the log
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f raycast.f --top-module raycast_tb -o raycast_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed"
  exit 1
fi

./obj_dir/raycast_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# the run counts as passed only if the pass line is in the log
if grep -qx "TEST OK" "$SIM_LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "pass line not found in $SIM_LOG"
exit 1

// ==== map.hex ====
// tile map, one line per row y = 0..23, columns are x = 0..23
// 0 is an open cell, any other digit is a wall type
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6 0 0 0 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6 0 0 0 0 0 0 4
3 0 0 0 0 0 5 5 0 0 0 0 0 0 0 0 6 0 0 0 0 0 0 4
3 0 0 0 0 0 5 5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 a 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4
3 0 0 0 7 7 7 7 7 7 0 0 0 0 0 0 0 0 0 0 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 8 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 9 0 0 0 0 0 0 0 0 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4
2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2
